/* project.f */
+incdir+.
common_pkg.sv
pipes_pkg.sv
step_if.sv
controller.sv
timer.sv
datapath.sv
core.sv
core_sva.sv
tb_core.sv

/* Bender.yml */
package:
  name: rv64_multicycle_core

export_include_dirs:
  - .

sources:
  - common_pkg.sv
  - pipes_pkg.sv
  - step_if.sv
  - controller.sv
  - timer.sv
  - datapath.sv
  - core.sv
  - target: test
    files:
      - core_sva.sv
      - tb_core.sv

/* tb_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module tb_core import common_pkg::*; ();

	// fetch and memory waits both at their limit, plus trap entry
	localparam int WORST_CPI = 14;
	localparam int HANDLER_AT = int'((`TRAP_VEC - `RESET_PC) / 4);
	localparam u64 DATA_BASE = 64'h1000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic iresp_data_ok = 1'b0;
	u32 iresp_data = '0;
	logic dresp_data_ok = 1'b0;
	u64 dresp_data = '0;
	logic ireq_valid;
	logic dreq_valid;
	logic dreq_write;
	u64 ireq_addr;
	u64 dreq_addr;
	u64 dreq_wdata;

	// alu ops and lui, stores to x10 = 0x1000, ld copy, branches, jal,
	// x20 cleared, zero to the compare through x11 = 0x0200_4000,
	// spin on x20, flag store, halt
	// zero words at 19, 21 and 23 sit on skipped paths
	u32 main_prog [31] = '{
		32'h00001537, 32'h06400093, 32'hff900113, 32'h002081b3,
		32'h40208233, 32'h0020f2b3, 32'h0020e333, 32'h0020c3b3,
		32'h12345437, 32'h00353023, 32'h00453423, 32'h00553823,
		32'h00653c23, 32'h02753023, 32'h02853423, 32'h08053483,
		32'h02953823, 32'h00208463, 32'h00209463, 32'h00000000,
		32'h00318463, 32'h00000000, 32'h008000ef, 32'h00000000,
		32'h02153c23, 32'h020045b7, 32'h00000a13, 32'h0005b023,
		32'h000a0063, 32'h05453023, 32'h0000006f
	};
	// compare back to all ones, x20 = 1, mret
	u32 handler [4] = '{32'hfff00613, 32'h00c5b023, 32'h00100a13, 32'h30200073};
	// word offsets from RESET_PC, spin once, trap, spin again after mret
	int fetch_order [33] = '{
		0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18,
		20, 22, 24, 25, 26, 27, 28, 64, 65, 66, 67, 28, 29, 30
	};

	u32 imem [128];
	u64 dmem [64];
	u64 fetch_q [$];
	u64 store_addr_q [$];
	u64 store_data_q [$];
	string store_name_q [$];
	integer seed = 32'hb8a6;
	int iwait = 0;
	int dwait = 0;
	int cycles = 0;
	int max_cycles;
	u64 a;
	u64 b;

	core uut (.*);

	always #50 clk = ~clk;

	task automatic end_with_failure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input u64 expected, input u64 actual);
		end_with_failure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic expect_store(input string name, input u64 offset, input u64 value);
		store_name_q.push_back(name);
		store_addr_q.push_back(DATA_BASE + offset);
		store_data_q.push_back(value);
	endtask

	function automatic u64 data_fill(input u64 addr);
		return {addr[63:32] ^ addr[31:0] ^ 32'h5a5a_c3c3, ~addr[31:0]};
	endfunction

	// both responders answer 0 to 3 cycles late
	always @(posedge clk) begin
		if (reset) begin
			iresp_data_ok <= 1'b0;
			dresp_data_ok <= 1'b0;
		end else begin
			if (iresp_data_ok) begin
				iresp_data_ok <= 1'b0;
			end else if (ireq_valid && iwait > 0) begin
				iwait <= iwait - 1;
			end else if (ireq_valid) begin
				assert (fetch_q.size() != 0) else end_with_failure("fetch past the end of the program");
				assert (ireq_addr == fetch_q[0]) else report_mismatch("fetch order", fetch_q[0], ireq_addr);
				void'(fetch_q.pop_front());
				iresp_data <= imem[ireq_addr[8:2]];
				iresp_data_ok <= 1'b1;
				iwait <= $random(seed) & 3;
			end
			if (dresp_data_ok) begin
				dresp_data_ok <= 1'b0;
			end else if (dreq_valid && dwait > 0) begin
				dwait <= dwait - 1;
			end else if (dreq_valid) begin
				assert (dreq_addr[63:9] == DATA_BASE[63:9])
					else end_with_failure("data access outside the data area");
				if (dreq_write) begin
					assert (store_addr_q.size() != 0) else end_with_failure("store the program never makes");
					assert (dreq_addr == store_addr_q[0])
						else report_mismatch({store_name_q[0], " address"}, store_addr_q[0], dreq_addr);
					assert (dreq_wdata == store_data_q[0])
						else report_mismatch(store_name_q[0], store_data_q[0], dreq_wdata);
					void'(store_name_q.pop_front());
					void'(store_addr_q.pop_front());
					void'(store_data_q.pop_front());
					dmem[dreq_addr[8:3]] <= dreq_wdata;
				end else begin
					dresp_data <= dmem[dreq_addr[8:3]];
				end
				dresp_data_ok <= 1'b1;
				dwait <= $random(seed) & 3;
			end
		end
	end

	initial begin
		foreach (main_prog[i])
			imem[i] = main_prog[i];
		foreach (handler[i])
			imem[HANDLER_AT + i] = handler[i];
		foreach (dmem[i])
			dmem[i] = data_fill(DATA_BASE + 8 * i);
		foreach (fetch_order[i])
			fetch_q.push_back(`RESET_PC + 4 * fetch_order[i]);
		a = 64'd100;
		b = -64'd7;
		expect_store("add", 0, a + b);
		expect_store("sub", 8, a - b);
		expect_store("and", 16, a & b);
		expect_store("or", 24, a | b);
		expect_store("xor", 32, a ^ b);
		expect_store("lui", 40, 64'h1234_5000);
		expect_store("ld copy", 48, data_fill(DATA_BASE + 64'h80));
		expect_store("jal link", 56, `RESET_PC + 4 * 23);
		expect_store("handler flag", 64, 64'd1);
		max_cycles = 4 * fetch_q.size() * WORST_CPI;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		while (fetch_q.size() != 0 || store_addr_q.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (uut.bus_check.fail_count != 0) begin
				end_with_failure("a bus or trap assertion failed");
			end
			if (cycles > max_cycles) begin
				end_with_failure($sformatf("timeout after %0d cycles", cycles));
			end
		end
		if (uut.bus_check.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			end_with_failure("a bus or trap assertion failed");
		end
	end

endmodule

`default_nettype wire

/* core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module core_sva import common_pkg::*; (
	input logic clk,
	input logic reset,
	input logic ireq_valid,
	input u64   ireq_addr,
	input logic iresp_data_ok,
	input logic dreq_valid,
	input logic dreq_write,
	input u64   dreq_addr,
	input u64   dreq_wdata,
	input logic dresp_data_ok,
	input logic take_trap,
	input logic in_trap
);

	// read from the testbench top
	int fail_count = 0;

	function automatic void note_failure(input string what);
		$error("%s", what);
		fail_count++;
	endfunction

	quiet_in_reset: assert property (@(posedge clk) reset |=> !ireq_valid && !dreq_valid)
		else note_failure("a request was valid during reset");

	// held until data_ok, dropped the cycle after it
	ireq_rule: assert property (@(posedge clk) disable iff (reset)
		ireq_valid |=> ($past(iresp_data_ok) ? !ireq_valid :
			(ireq_valid && $stable(ireq_addr))))
		else note_failure("instruction request broke the handshake");

	dreq_rule: assert property (@(posedge clk) disable iff (reset)
		dreq_valid |=> ($past(dresp_data_ok) ? !dreq_valid :
			(dreq_valid && $stable(dreq_addr) && $stable(dreq_wdata) &&
			$stable(dreq_write))))
		else note_failure("data request broke the handshake");

	no_nested_trap: assert property (@(posedge clk) disable iff (reset)
		take_trap |-> !in_trap)
		else note_failure("trap taken inside the handler");

endmodule

bind core core_sva bus_check (
	.*,
	.take_trap(step.take_trap),
	.in_trap(controller.in_trap)
);

`default_nettype wire

/* core.sv */
`timescale 1ns/100ps
`default_nettype none

module core import common_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic ireq_valid,
	output u64   ireq_addr,
	input  logic iresp_data_ok,
	input  u32   iresp_data,
	output logic dreq_valid,
	output logic dreq_write,
	output u64   dreq_addr,
	output u64   dreq_wdata,
	input  logic dresp_data_ok,
	input  u64   dresp_data
);

	logic pending;
	logic cmp_we;
	u64 cmp_data;

	step_if step ();

	controller controller (
		.clk(clk),
		.reset(reset),
		.step(step),
		.pending(pending),
		.cmp_we(cmp_we),
		.cmp_data(cmp_data),
		.ireq_valid(ireq_valid),
		.iresp_data_ok(iresp_data_ok),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dresp_data_ok(dresp_data_ok)
	);

	timer timer (
		.clk(clk),
		.reset(reset),
		.cmp_we(cmp_we),
		.cmp_data(cmp_data),
		.pending(pending)
	);

	// pc drives the fetch address directly
	datapath datapath (
		.clk(clk),
		.reset(reset),
		.step(step),
		.instr(iresp_data),
		.rdata(dresp_data),
		.pc(ireq_addr),
		.daddr(dreq_addr),
		.wdata(dreq_wdata)
	);

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module datapath import common_pkg::*, pipes_pkg::*; (
	input  logic clk,
	input  logic reset,
	step_if.dp   step,
	input  u32   instr,
	input  u64   rdata,
	output u64   pc,
	output u64   daddr,
	output u64   wdata
);

	u32 ir;
	decoded_t dec;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t regs [`NUM_REGS];
	word_t rs1_val, rs2_val;
	word_t alu_out, alu_res, load_data;
	logic branch_cond, taken;
	logic writes_rd;
	u64 mepc;

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	always_comb begin
		dec.op = ILLEGAL;
		dec.rd = ir[11:7];
		dec.rs1 = ir[19:15];
		dec.rs2 = ir[24:20];
		dec.imm = '0;
		case (opcode)
			7'b0010011: begin
				dec.imm = {{52{ir[31]}}, ir[31:20]};
				if (funct3 == 3'b000) begin
					dec.op = ADDI;
				end
			end
			7'b0110011: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: dec.op = ADD;
						3'b111: dec.op = AND;
						3'b110: dec.op = OR;
						3'b100: dec.op = XOR;
						default: dec.op = ILLEGAL;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec.op = SUB;
				end
			end
			7'b0110111: begin
				dec.op = LUI;
				dec.imm = {{32{ir[31]}}, ir[31:12], 12'b0};
			end
			7'b0000011: begin
				dec.imm = {{52{ir[31]}}, ir[31:20]};
				if (funct3 == 3'b011) begin
					dec.op = LD;
				end
			end
			7'b0100011: begin
				dec.imm = {{52{ir[31]}}, ir[31:25], ir[11:7]};
				if (funct3 == 3'b011) begin
					dec.op = SD;
				end
			end
			7'b1100011: begin
				dec.imm = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
				if (funct3 == 3'b000) begin
					dec.op = BEQ;
				end else if (funct3 == 3'b001) begin
					dec.op = BNE;
				end
			end
			7'b1101111: begin
				dec.op = JAL;
				dec.imm = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			end
			7'b1110011: begin
				if (ir == 32'h3020_0073) begin
					dec.op = MRET;
				end
			end
			default: dec.op = ILLEGAL;
		endcase
	end

	// x0 reads zero
	assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
	assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

	always_comb begin
		case (dec.op)
			ADDI: alu_out = rs1_val + dec.imm;
			ADD: alu_out = rs1_val + rs2_val;
			SUB: alu_out = rs1_val - rs2_val;
			AND: alu_out = rs1_val & rs2_val;
			OR: alu_out = rs1_val | rs2_val;
			XOR: alu_out = rs1_val ^ rs2_val;
			LUI: alu_out = dec.imm;
			JAL: alu_out = pc + 64'd4;
			default: alu_out = '0;
		endcase
	end

	assign branch_cond = (dec.op == JAL) ||
		(dec.op == BEQ && rs1_val == rs2_val) ||
		(dec.op == BNE && rs1_val != rs2_val);

	assign writes_rd = (dec.op == ADDI) || (dec.op == ADD) || (dec.op == SUB) ||
		(dec.op == AND) || (dec.op == OR) || (dec.op == XOR) ||
		(dec.op == LUI) || (dec.op == LD) || (dec.op == JAL);

	// registers hold still until wb, so the bus address stays stable through MEM
	assign daddr = rs1_val + dec.imm;
	assign wdata = rs2_val;

	assign step.op = dec.op;
	assign step.mem_addr = daddr;
	assign step.store_data = wdata;

	always_ff @(posedge clk) begin
		if (step.load_ir) begin
			ir <= instr;
		end
		if (step.exec) begin
			alu_res <= alu_out;
			taken <= branch_cond;
		end
		if (step.mem_ok) begin
			load_data <= rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (step.wb && writes_rd && dec.rd != '0) begin
			regs[dec.rd] <= (dec.op == LD) ? load_data : alu_res;
		end
	end

	// pc has already moved past the retired instruction when the trap is taken
	always_ff @(posedge clk) begin
		if (step.take_trap) begin
			mepc <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (step.take_trap) begin
			pc <= `TRAP_VEC;
		end else if (step.wb) begin
			if (dec.op == MRET) begin
				pc <= mepc;
			end else if (taken) begin
				pc <= pc + dec.imm;
			end else begin
				pc <= pc + 64'd4;
			end
		end
	end

endmodule

`default_nettype wire

/* timer.sv */
`timescale 1ns/100ps
`default_nettype none

module timer import common_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic cmp_we,
	input  u64   cmp_data,
	output logic pending
);

	u64 count;
	u64 cmp;

	// free-running cycle count
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 64'd1;
		end
	end

	// compare at all ones keeps the interrupt quiet until software sets it
	always_ff @(posedge clk) begin
		if (reset) begin
			cmp <= '1;
			pending <= 1'b0;
		end else if (cmp_we) begin
			cmp <= cmp_data;
			pending <= 1'b0;
		end else begin
			pending <= (count >= cmp);
		end
	end

endmodule

`default_nettype wire

/* controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module controller import common_pkg::*, pipes_pkg::*; (
	input  logic clk,
	input  logic reset,
	step_if.ctl  step,
	input  logic pending,
	output logic cmp_we,
	output u64   cmp_data,
	output logic ireq_valid,
	input  logic iresp_data_ok,
	output logic dreq_valid,
	output logic dreq_write,
	input  logic dresp_data_ok
);

	state_t state, state_next;
	logic in_trap;
	logic mem_op;
	logic cmp_store;

	assign mem_op = (step.op == LD) || (step.op == SD);

	// timer compare store, handled locally in one MEM cycle
	assign cmp_store = (step.op == SD) && (step.mem_addr == `MTIMECMP_ADDR);

	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				if (ireq_valid && iresp_data_ok) begin
					state_next = EXEC;
				end
			end
			EXEC: begin
				state_next = mem_op ? MEM : WB;
			end
			MEM: begin
				if (cmp_store || (dreq_valid && dresp_data_ok)) begin
					state_next = WB;
				end
			end
			WB: begin
				// MRET retires with in_trap still set, so no trap on it
				state_next = (pending && !in_trap) ? TRAP : FETCH;
			end
			TRAP: begin
				state_next = FETCH;
			end
			default: begin
				state_next = FETCH;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
			in_trap <= 1'b0;
			ireq_valid <= 1'b0;
			dreq_valid <= 1'b0;
		end else begin
			state <= state_next;
			// requests rise on state entry and fall after data_ok
			ireq_valid <= (state_next == FETCH);
			dreq_valid <= (state_next == MEM) && !cmp_store;
			if (state == TRAP) begin
				in_trap <= 1'b1;
			end else if (state == WB && step.op == MRET) begin
				in_trap <= 1'b0;
			end
		end
	end

	assign dreq_write = dreq_valid && (step.op == SD);

	assign cmp_we = (state == MEM) && cmp_store;
	assign cmp_data = step.store_data;

	assign step.load_ir = (state == FETCH) && ireq_valid && iresp_data_ok;
	assign step.exec = (state == EXEC);
	assign step.mem_ok = (state == MEM) && dreq_valid && dresp_data_ok;
	assign step.wb = (state == WB);
	assign step.take_trap = (state == TRAP);

endmodule

`default_nettype wire

/* step_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface step_if import common_pkg::*, pipes_pkg::*; ();

	// one strobe per controller state
	logic load_ir;
	logic exec;
	logic mem_ok;
	logic wb;
	logic take_trap;

	// decode results back to the controller
	op_t op;
	u64  mem_addr;
	u64  store_data;

	modport ctl (
		output load_ir, exec, mem_ok, wb, take_trap,
		input  op, mem_addr, store_data
	);

	modport dp (
		input  load_ir, exec, mem_ok, wb, take_trap,
		output op, mem_addr, store_data
	);

endinterface

`default_nettype wire

/* pipes_pkg.sv */
`default_nettype none

package pipes_pkg;
	import common_pkg::*;

	// ILLEGAL retires as a no-op
	typedef enum logic [3:0] {
		ADDI,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		LUI,
		LD,
		SD,
		BEQ,
		BNE,
		JAL,
		MRET,
		ILLEGAL
	} op_t;

	typedef enum logic [2:0] {
		FETCH,
		EXEC,
		MEM,
		WB,
		TRAP
	} state_t;

	// imm is already sign-extended to 64 bits
	typedef struct packed {
		op_t        op;
		creg_addr_t rd;
		creg_addr_t rs1;
		creg_addr_t rs2;
		word_t      imm;
	} decoded_t;

endpackage

`default_nettype wire

/* common_pkg.sv */
`default_nettype none

package common_pkg;

	// address or 64-bit data word
	typedef logic [63:0] u64;

	// instruction word
	typedef logic [31:0] u32;

	// register index
	typedef logic [4:0] creg_addr_t;

	// register value
	typedef logic [63:0] word_t;

endpackage

`default_nettype wire

/* core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch after reset
`define RESET_PC 64'h0000_0000_8000_0000

// timer interrupt entry point
`define TRAP_VEC 64'h0000_0000_8000_0100

// a store here sets the timer compare and never reaches the bus
`define MTIMECMP_ADDR 64'h0000_0000_0200_4000

// x0..x31
`define NUM_REGS 32

`endif
